//--- axis_frame_fifo.f
verilog/fifo_pkg.sv
verilog/fifo_mem_if.sv
verilog/frame_write_ctrl.sv
verilog/fifo_ram.sv
verilog/read_pipeline.sv
verilog/axis_frame_fifo.sv
verification/tb_clock.sv
verification/axis_frame_fifo_asserts.sv
verification/tb_axis_frame_fifo.sv

//--- Makefile
TOP := tb_axis_frame_fifo

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal \
		--top-module $(TOP) -f axis_frame_fifo.f -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	grep -q ">>> PASS" sim.log

clean:
	rm -rf obj_dir sim.log

//--- verification/tb_axis_frame_fifo.sv
`timescale 1ns/1ps

module tb_axis_frame_fifo;

  localparam int NUM_TESTS = 24;

  logic                            clk;
  logic                            rst;
  logic [fifo_pkg::DATA_WIDTH-1:0] s_tdata;
  logic                            s_tvalid;
  logic                            s_tready;
  logic                            s_tlast;
  logic                            s_tuser;
  logic [fifo_pkg::DATA_WIDTH-1:0] m_tdata;
  logic                            m_tvalid;
  logic                            m_tready = 1'b0;
  logic                            m_tlast;
  logic                            m_tuser;
  logic                            status_overflow;
  logic                            status_bad_frame;
  logic                            status_good_frame;

  // ##############################
  // frame table
  // ##############################
  string tst_name [NUM_TESTS] = '{
    "good_len1", "good_len2", "good_len3", "good_len4", "good_len5", "good_len6",
    "good_len7", "good_len8", "bad_mid", "good_after_bad", "bad_single",
    "good_after_bad2", "overlong_20", "good_after_over", "stall30_a", "stall30_b",
    "stall70_a", "stall70_b", "pause_a", "pause_b", "pause_c", "pause_bad",
    "good_full16", "good_final"};
  int    tst_len   [NUM_TESTS] = '{1, 2, 3, 4, 5, 6, 7, 8, 5, 4, 1, 3,
                                   20, 6, 7, 3, 8, 5, 6, 7, 8, 4, 16, 2};
  bit    tst_bad   [NUM_TESTS] = '{0, 0, 0, 0, 0, 0, 0, 0, 1, 0, 1, 0,
                                   0, 0, 0, 0, 0, 0, 0, 0, 0, 1, 0, 0};
  int    tst_stall [NUM_TESTS] = '{0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0,
                                   0, 0, 30, 30, 70, 70, 0, 0, 0, 0, 0, 50};
  bit    tst_pause [NUM_TESTS] = '{0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0,
                                   0, 0, 0, 0, 0, 0, 1, 1, 1, 1, 0, 0};

  integer      data_seed = 32'hec6d_44e9;
  integer      ready_seed = 32'hec6d_44e9;
  int unsigned ready_rnd;
  int          stall_pct = 0;
  bit          drain_paused = 1'b0;
  bit          finished_ok = 1'b0;
  bit          fail_shown = 1'b0;
  int          exp_good = 0;
  int          exp_bad = 0;
  int          exp_overflow = 0;
  int          seen_good = 0;
  int          seen_bad = 0;
  int          seen_overflow = 0;
  int          pause_stalls = 0;
  int          frame_stalls = 0;

  logic [fifo_pkg::DATA_WIDTH-1:0] exp_data [$];
  logic                            exp_last [$];
  logic                            exp_user [$];
  int                              exp_test [$];
  int                              mon_idx;
  logic [fifo_pkg::DATA_WIDTH-1:0] mon_data;
  logic                            mon_last;
  logic                            mon_user;

  tb_clock clk0 (.clk(clk));

  axis_frame_fifo dut0 (.*);

  task automatic check_value(input string what, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (expected !== actual) begin
      $display("FAIL %s expected %0h actual %0h", what, expected, actual);
      fail_shown = 1'b1;
      $display(">>> FAIL");
      $fatal(1, "value mismatch");
    end
  endtask

  // called on a rising edge, returns on the edge that takes the beat
  task automatic send_beat(input logic [7:0] data, input logic last, input logic user);
    int waited;
    waited = 0;
    s_tvalid <= 1'b1;
    s_tdata  <= data;
    s_tlast  <= last;
    s_tuser  <= user;
    @(negedge clk);
    while (!s_tready) begin
      frame_stalls++;
      if (drain_paused) begin
        pause_stalls++;
        waited++;
        if (waited >= 8) begin
          drain_paused = 1'b0;  // let the reader free space
        end
      end
      @(negedge clk);
    end
    @(posedge clk);
  endtask

  task automatic send_frame(input int idx);
    logic [31:0] rnd;
    logic        last;
    logic        user;
    bit          keep;
    keep = (tst_len[idx] <= fifo_pkg::DEPTH) && !tst_bad[idx];
    if (tst_len[idx] > fifo_pkg::DEPTH) begin
      exp_overflow++;
    end else if (tst_bad[idx]) begin
      exp_bad++;
    end else begin
      exp_good++;
    end
    frame_stalls = 0;
    @(posedge clk);
    for (int b = 0; b < tst_len[idx]; b++) begin
      rnd  = $random(data_seed);
      last = (b == tst_len[idx] - 1);
      user = last ? tst_bad[idx] : rnd[8];
      if (keep) begin
        exp_data.push_back(rnd[7:0]);
        exp_last.push_back(last);
        exp_user.push_back(user);
        exp_test.push_back(idx);
      end
      send_beat(rnd[7:0], last, user);
    end
    s_tvalid <= 1'b0;
    s_tlast  <= 1'b0;
    s_tuser  <= 1'b0;
    if (tst_len[idx] > fifo_pkg::DEPTH) begin
      check_value({tst_name[idx], " input stalls"}, 32'd0, 32'(frame_stalls));
    end
  endtask

  // ##############################
  // output side
  // ##############################
  always @(posedge clk) begin
    if (rst || drain_paused) begin
      m_tready <= 1'b0;
    end else begin
      ready_rnd = $random(ready_seed);
      m_tready <= (ready_rnd % 100) >= stall_pct;
    end
  end

  always @(negedge clk) begin
    if (!rst && m_tvalid && m_tready) begin
      if (exp_data.size() == 0) begin
        fail_shown = 1'b1;
        $display("an output beat arrived while no frame was expected");
        $display(">>> FAIL");
        $fatal(1, "unexpected output beat");
      end else begin
        mon_idx  = exp_test.pop_front();
        mon_data = exp_data.pop_front();
        mon_last = exp_last.pop_front();
        mon_user = exp_user.pop_front();
        check_value({tst_name[mon_idx], " data"}, 32'(mon_data), 32'(m_tdata));
        check_value({tst_name[mon_idx], " last"}, 32'(mon_last), 32'(m_tlast));
        check_value({tst_name[mon_idx], " user"}, 32'(mon_user), 32'(m_tuser));
      end
    end
  end

  always @(negedge clk) begin
    if (!rst) begin
      if (status_good_frame) seen_good++;
      if (status_bad_frame) seen_bad++;
      if (status_overflow) seen_overflow++;
    end
  end

  // ##############################
  // sequence
  // ##############################
  initial begin
    rst      = 1'b1;
    s_tvalid = 1'b0;
    s_tdata  = '0;
    s_tlast  = 1'b0;
    s_tuser  = 1'b0;
    repeat (16) @(posedge clk);
    rst <= 1'b0;
    for (int i = 0; i < NUM_TESTS; i++) begin
      @(negedge clk);
      drain_paused = tst_pause[i];
      stall_pct    = tst_stall[i];
      send_frame(i);
    end
    @(negedge clk);
    drain_paused = 1'b0;
    stall_pct    = 0;
    while (exp_data.size() != 0) @(negedge clk);
    repeat (20) @(negedge clk);  // late pulses and stray beats
    check_value("good frame count", exp_good, seen_good);
    check_value("bad frame count", exp_bad, seen_bad);
    check_value("overflow count", exp_overflow, seen_overflow);
    check_value("input stall with draining paused", 32'd1, 32'(pause_stalls > 0));
    finished_ok = 1'b1;
    $display(">>> PASS");
    $finish;
  end

  initial begin : watchdog
    int limit;
    limit = 200;
    for (int i = 0; i < NUM_TESTS; i++) begin
      limit += 40 * tst_len[i];
    end
    repeat (limit) @(posedge clk);
    fail_shown = 1'b1;
    $display("timeout: the run did not finish within %0d cycles", limit);
    $display(">>> FAIL");
    $fatal(1, "watchdog expired");
  end

  // the run was stopped from outside this module, e.g. by an assertion
  final begin
    if (!finished_ok && !fail_shown) begin
      $display("the run stopped before all checks were done");
      $display(">>> FAIL");
    end
  end

endmodule

//--- verification/axis_frame_fifo_asserts.sv
`timescale 1ns/1ps

module axis_frame_fifo_asserts (
  input logic                            clk,
  input logic                            rst,
  input logic [fifo_pkg::DATA_WIDTH-1:0] m_tdata,
  input logic                            m_tvalid,
  input logic                            m_tready,
  input logic                            m_tlast,
  input logic                            m_tuser,
  input logic                            s_tready,
  input logic                            status_overflow,
  input logic                            status_bad_frame,
  input logic                            status_good_frame
);

  // ##############################
  // reset
  // ##############################
  valid_low_after_reset: assert property (@(posedge clk) rst |=> !m_tvalid)
    else $error("m_tvalid high right after a reset cycle");

  ready_at_reset_release: assert property (@(posedge clk) $fell(rst) |-> s_tready)
    else $error("s_tready low when reset was released");

  // ##############################
  // output stream and status
  // ##############################
  output_held_on_stall: assert property (@(posedge clk) disable iff (rst)
    m_tvalid && !m_tready |=>
      m_tvalid && $stable(m_tdata) && $stable(m_tlast) && $stable(m_tuser))
    else $error("output beat changed while stalled");

  status_one_at_a_time: assert property (@(posedge clk) disable iff (rst)
    $onehot0({status_overflow, status_bad_frame, status_good_frame}))
    else $error("two status pulses in the same cycle");

endmodule

bind axis_frame_fifo axis_frame_fifo_asserts asserts0 (
  .clk               (clk),
  .rst               (rst),
  .m_tdata           (m_tdata),
  .m_tvalid          (m_tvalid),
  .m_tready          (m_tready),
  .m_tlast           (m_tlast),
  .m_tuser           (m_tuser),
  .s_tready          (s_tready),
  .status_overflow   (status_overflow),
  .status_bad_frame  (status_bad_frame),
  .status_good_frame (status_good_frame)
);

//--- verification/tb_clock.sv
`timescale 1ns/1ps

module tb_clock (
  output logic clk
);

  // 4 ns period
  initial begin
    clk = 1'b0;
    forever begin
      #2 clk = ~clk;
    end
  end

endmodule

//--- verilog/axis_frame_fifo.sv
`timescale 1ns/1ps

module axis_frame_fifo (
  input  logic                            clk,
  input  logic                            rst,

  // slave stream
  input  logic [fifo_pkg::DATA_WIDTH-1:0] s_tdata,
  input  logic                            s_tvalid,
  output logic                            s_tready,
  input  logic                            s_tlast,
  input  logic                            s_tuser,

  // master stream
  output logic [fifo_pkg::DATA_WIDTH-1:0] m_tdata,
  output logic                            m_tvalid,
  input  logic                            m_tready,
  output logic                            m_tlast,
  output logic                            m_tuser,

  // status pulses
  output logic                            status_overflow,
  output logic                            status_bad_frame,
  output logic                            status_good_frame
);

  fifo_pkg::ptr_t commit_ptr;  // end of last good frame
  fifo_pkg::ptr_t rd_ptr;

  fifo_mem_if mem0 ();

  // ##############################
  // write side
  // ##############################
  frame_write_ctrl wr0 (
    .clk               (clk),
    .rst               (rst),
    .s_tdata           (s_tdata),
    .s_tvalid          (s_tvalid),
    .s_tlast           (s_tlast),
    .s_tuser           (s_tuser),
    .s_tready          (s_tready),
    .rd_ptr            (rd_ptr),
    .commit_ptr        (commit_ptr),
    .mem               (mem0.writer),
    .status_overflow   (status_overflow),
    .status_bad_frame  (status_bad_frame),
    .status_good_frame (status_good_frame)
  );

  fifo_ram ram0 (
    .clk (clk),
    .mem (mem0.ram)
  );

  // ##############################
  // read side
  // ##############################
  read_pipeline rd0 (
    .clk        (clk),
    .rst        (rst),
    .commit_ptr (commit_ptr),
    .rd_ptr     (rd_ptr),
    .mem        (mem0.reader),
    .m_tdata    (m_tdata),
    .m_tvalid   (m_tvalid),
    .m_tlast    (m_tlast),
    .m_tuser    (m_tuser),
    .m_tready   (m_tready)
  );

endmodule

//--- verilog/read_pipeline.sv
`timescale 1ns/1ps

module read_pipeline (
  input  logic                            clk,
  input  logic                            rst,
  input  fifo_pkg::ptr_t                  commit_ptr,
  output fifo_pkg::ptr_t                  rd_ptr,
  fifo_mem_if.reader                      mem,
  output logic [fifo_pkg::DATA_WIDTH-1:0] m_tdata,
  output logic                            m_tvalid,
  output logic                            m_tlast,
  output logic                            m_tuser,
  input  logic                            m_tready
);

  logic                 rd_valid;      // mem.rd_data holds a word
  logic                 store_output;  // output register can take a word
  logic                 read;
  fifo_pkg::fifo_word_t out_word;

  assign store_output = m_tready || !m_tvalid;
  assign read         = (rd_ptr != commit_ptr) && (store_output || !rd_valid);

  assign mem.rd_en   = read;
  assign mem.rd_addr = rd_ptr[fifo_pkg::ADDR_WIDTH-1:0];

  // ##############################
  // RAM read stage
  // ##############################
  always_ff @(posedge clk) begin
    if (rst) begin
      rd_ptr   <= '0;
      rd_valid <= 1'b0;
    end else begin
      if (read) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      if (store_output || !rd_valid) begin
        rd_valid <= read;  // stage refills or empties
      end
    end
  end

  // ##############################
  // output register
  // ##############################
  always_ff @(posedge clk) begin
    if (rst) begin
      m_tvalid <= 1'b0;
    end else if (store_output) begin
      m_tvalid <= rd_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (store_output) begin
      out_word <= mem.rd_data;
    end
  end

  assign m_tdata = out_word.data;
  assign m_tlast = out_word.last;
  assign m_tuser = out_word.user;

endmodule

//--- verilog/fifo_ram.sv
`timescale 1ns/1ps

module fifo_ram (
  input logic     clk,
  fifo_mem_if.ram mem
);

  fifo_pkg::fifo_word_t ram [fifo_pkg::DEPTH];

  // ##############################
  // write port
  // ##############################
  always_ff @(posedge clk) begin
    if (mem.wr_en) begin
      ram[mem.wr_addr] <= mem.wr_data;
    end
  end

  // ##############################
  // read port
  // ##############################

  // output register holds its word while rd_en is low
  always_ff @(posedge clk) begin
    if (mem.rd_en) begin
      mem.rd_data <= ram[mem.rd_addr];
    end
  end

endmodule

//--- verilog/frame_write_ctrl.sv
`timescale 1ns/1ps

module frame_write_ctrl (
  input  logic                            clk,
  input  logic                            rst,
  input  logic [fifo_pkg::DATA_WIDTH-1:0] s_tdata,
  input  logic                            s_tvalid,
  input  logic                            s_tlast,
  input  logic                            s_tuser,
  output logic                            s_tready,
  input  fifo_pkg::ptr_t                  rd_ptr,
  output fifo_pkg::ptr_t                  commit_ptr,
  fifo_mem_if.writer                      mem,
  output logic                            status_overflow,
  output logic                            status_bad_frame,
  output logic                            status_good_frame
);

  fifo_pkg::ptr_t      wr_ptr;       // working pointer, ahead of commit_ptr
  fifo_pkg::ptr_t      wr_ptr_next;
  fifo_pkg::ptr_t      commit_next;
  fifo_pkg::wr_state_e state;
  fifo_pkg::wr_state_e state_next;
  logic                full_cur;
  logic                full_wr;
  logic                overflow_next;
  logic                bad_next;
  logic                good_next;

  // working pointer has caught up with the reader
  assign full_cur = (wr_ptr[fifo_pkg::ADDR_WIDTH] != rd_ptr[fifo_pkg::ADDR_WIDTH]) &&
                    (wr_ptr[fifo_pkg::ADDR_WIDTH-1:0] == rd_ptr[fifo_pkg::ADDR_WIDTH-1:0]);

  // open frame already fills the whole RAM
  assign full_wr = (wr_ptr[fifo_pkg::ADDR_WIDTH] != commit_ptr[fifo_pkg::ADDR_WIDTH]) &&
                   (wr_ptr[fifo_pkg::ADDR_WIDTH-1:0] == commit_ptr[fifo_pkg::ADDR_WIDTH-1:0]);

  assign s_tready = !full_cur || full_wr || (state == fifo_pkg::WR_DROP);

  assign mem.wr_addr = wr_ptr[fifo_pkg::ADDR_WIDTH-1:0];
  assign mem.wr_data = '{data: s_tdata, last: s_tlast, user: s_tuser};

  // ##############################
  // accept, commit, rollback
  // ##############################
  always_comb begin
    wr_ptr_next   = wr_ptr;
    commit_next   = commit_ptr;
    state_next    = state;
    overflow_next = 1'b0;
    bad_next      = 1'b0;
    good_next     = 1'b0;
    mem.wr_en     = 1'b0;
    if (s_tvalid && s_tready) begin
      if (state == fifo_pkg::WR_DROP || full_wr) begin
        state_next = fifo_pkg::WR_DROP;  // too long, keep consuming
        if (s_tlast) begin
          wr_ptr_next   = commit_ptr;
          state_next    = fifo_pkg::WR_PASS;
          overflow_next = 1'b1;
        end
      end else begin
        mem.wr_en   = 1'b1;
        wr_ptr_next = wr_ptr + 1'b1;
        if (s_tlast) begin
          if (s_tuser) begin
            wr_ptr_next = commit_ptr;  // bad frame, roll back
            bad_next    = 1'b1;
          end else begin
            commit_next = wr_ptr + 1'b1;
            good_next   = 1'b1;
          end
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr            <= '0;
      commit_ptr        <= '0;
      state             <= fifo_pkg::WR_PASS;
      status_overflow   <= 1'b0;
      status_bad_frame  <= 1'b0;
      status_good_frame <= 1'b0;
    end else begin
      wr_ptr            <= wr_ptr_next;
      commit_ptr        <= commit_next;
      state             <= state_next;
      status_overflow   <= overflow_next;
      status_bad_frame  <= bad_next;
      status_good_frame <= good_next;
    end
  end

endmodule

//--- verilog/fifo_mem_if.sv
`timescale 1ns/1ps

interface fifo_mem_if;

  logic                              wr_en;
  logic [fifo_pkg::ADDR_WIDTH-1:0]   wr_addr;
  fifo_pkg::fifo_word_t              wr_data;

  logic                              rd_en;
  logic [fifo_pkg::ADDR_WIDTH-1:0]   rd_addr;
  fifo_pkg::fifo_word_t              rd_data;  // registered in the RAM

  modport writer (
    output wr_en, wr_addr, wr_data
  );

  modport reader (
    output rd_en, rd_addr,
    input  rd_data
  );

  modport ram (
    input  wr_en, wr_addr, wr_data,
    input  rd_en, rd_addr,
    output rd_data
  );

endinterface

//--- verilog/fifo_pkg.sv
package fifo_pkg;

  // ##############################
  // sizes
  // ##############################
  localparam int ADDR_WIDTH = 4;
  localparam int DEPTH      = 2 ** ADDR_WIDTH;  // 16 words
  localparam int DATA_WIDTH = 8;

  // ##############################
  // types
  // ##############################

  // one extra bit separates full from empty
  typedef logic [ADDR_WIDTH:0] ptr_t;

  // one stored beat
  typedef struct packed {
    logic [DATA_WIDTH-1:0] data;
    logic                  last;
    logic                  user;
  } fifo_word_t;

  typedef enum logic {
    WR_PASS,  // writing or waiting for space
    WR_DROP   // swallowing the rest of an overlong frame
  } wr_state_e;

endpackage
